// File: design/execPkg.sv
`default_nettype none

package execPkg;

	// --------------------
	// Encodings
	// --------------------

	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		RSB = 4'd2, // Reverse subtract.
		AND = 4'd3,
		ORR = 4'd4,
		EOR = 4'd5,
		BIC = 4'd6, // A and not B.
		MOV = 4'd7,
		MUL = 4'd8,
		MLA = 4'd9  // Multiply plus third operand.
	} aluOp_e;

	typedef enum logic [3:0] {
		EQ = 4'd0,
		NE = 4'd1,
		CS = 4'd2,
		CC = 4'd3,
		MI = 4'd4,
		PL = 4'd5,
		VS = 4'd6,
		VC = 4'd7,
		HI = 4'd8,
		LS = 4'd9,
		GE = 4'd10,
		LT = 4'd11,
		GT = 4'd12,
		LE = 4'd13,
		AL = 4'd14
	} cond_e;

	typedef enum logic [1:0] {
		REG = 2'd0,
		WB  = 2'd1,
		MEM = 2'd2
	} fwdSel_e;

	// --------------------
	// Structs
	// --------------------

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	typedef struct packed {
		logic       regWrite;
		logic       pcSrc;
		logic       branch;
		logic       memToReg;
		logic       flagWrite;
		logic       aluSrc;   // Select immediate for operand B.
		aluOp_e     aluOp;
		cond_e      cond;
		logic [3:0] wa3;
	} exCtrl_t;

	typedef struct packed {
		logic [31:0] aluResult;
		logic [31:0] writeData;
		logic [3:0]  wa3;
		logic        regWrite;
		logic        pcSrc;
		logic        memToReg;
	} memStage_t;

endpackage

`default_nettype wire

// File: design/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input  logic [31:0]     inputA,
	input  logic [31:0]     inputB,
	input  logic [31:0]     inputC,
	input  execPkg::aluOp_e aluOp,
	output logic [31:0]     result,
	output execPkg::flags_t aluFlags
);

	logic [31:0] addX;
	logic [31:0] addY;
	logic        carryIn;
	logic [32:0] sum;
	logic [31:0] product;
	logic [31:0] mulResult;
	logic        isArith;

	// --------------------
	// Adder operand setup
	// --------------------
	always_comb begin
		addX    = inputA;
		addY    = inputB;
		carryIn = 1'b0;
		case (aluOp)
			execPkg::SUB: begin
				addY    = ~inputB;    // A + ~B + 1.
				carryIn = 1'b1;
			end
			execPkg::RSB: begin
				addX    = inputB;     // B + ~A + 1.
				addY    = ~inputA;
				carryIn = 1'b1;
			end
			default: ;
		endcase
	end

	assign sum       = {1'b0, addX} + {1'b0, addY} + {32'd0, carryIn};
	assign product   = inputA * inputB;                // Low word only.
	assign mulResult = (aluOp == execPkg::MLA) ? product + inputC : product;
	assign isArith   = (aluOp == execPkg::ADD) || (aluOp == execPkg::SUB) ||
	                   (aluOp == execPkg::RSB);

	always_comb begin
		case (aluOp)
			execPkg::ADD,
			execPkg::SUB,
			execPkg::RSB: result = sum[31:0];
			execPkg::AND: result = inputA & inputB;
			execPkg::ORR: result = inputA | inputB;
			execPkg::EOR: result = inputA ^ inputB;
			execPkg::BIC: result = inputA & ~inputB;
			execPkg::MOV: result = inputB;
			execPkg::MUL,
			execPkg::MLA: result = mulResult;
			default:      result = 32'd0;
		endcase
	end

	// Carry is "no borrow" on subtraction since the adder inverts.
	assign aluFlags = '{
		n: result[31],
		z: (result == 32'd0),
		c: isArith & sum[32],
		v: isArith & (addX[31] == addY[31]) & (sum[31] != addX[31])
	};

endmodule

`default_nettype wire

// File: design/condUnit.sv
`timescale 1ns/100ps
`default_nettype none

module condUnit (
	input  logic            Clk,
	input  logic            reset,
	input  execPkg::flags_t aluFlags,
	input  execPkg::cond_e  cond,
	input  logic            flagWrite,
	output logic            condEx,
	output execPkg::flags_t flags
);

	// --------------------
	// NZCV register
	// --------------------
	always_ff @(posedge Clk) begin
		if (reset) begin
			flags <= '0;
		end else if (flagWrite && condEx) begin
			flags <= aluFlags;           // Only passing instructions update.
		end
	end

	// --------------------
	// Condition check
	// --------------------
	always_comb begin
		case (cond)
			execPkg::EQ: condEx = flags.z;
			execPkg::NE: condEx = !flags.z;
			execPkg::CS: condEx = flags.c;
			execPkg::CC: condEx = !flags.c;
			execPkg::MI: condEx = flags.n;
			execPkg::PL: condEx = !flags.n;
			execPkg::VS: condEx = flags.v;
			execPkg::VC: condEx = !flags.v;
			execPkg::HI: condEx = flags.c && !flags.z;
			execPkg::LS: condEx = !flags.c || flags.z;
			execPkg::GE: condEx = (flags.n == flags.v);
			execPkg::LT: condEx = (flags.n != flags.v);
			execPkg::GT: condEx = !flags.z && (flags.n == flags.v);
			execPkg::LE: condEx = flags.z || (flags.n != flags.v);
			default:     condEx = 1'b1;  // AL, and code 15 behaves the same.
		endcase
	end

	flagsClearAfterReset: assert property (
		@(posedge Clk) reset |=> (flags == 4'b0000)
	) else $error("condUnit: flags not cleared after reset");

endmodule

`default_nettype wire

// File: design/forwardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module forwardUnit (
	input  logic               [3:0] ra1E,
	input  logic               [3:0] ra2E,
	input  execPkg::memStage_t       memStage,
	input  logic               [3:0] wa3W,
	input  logic                     regWriteW,
	output execPkg::fwdSel_e         forwardA,
	output execPkg::fwdSel_e         forwardB
);

	// Memory stage is newer than writeback, so it wins a tie.
	function automatic execPkg::fwdSel_e pickSource(
		input logic [3:0] srcReg,
		input logic [3:0] memWa3,
		input logic       memRegWrite,
		input logic [3:0] wbWa3,
		input logic       wbRegWrite
	);
		execPkg::fwdSel_e sel;
		if (memRegWrite && (memWa3 == srcReg)) begin
			sel = execPkg::MEM;
		end else if (wbRegWrite && (wbWa3 == srcReg)) begin
			sel = execPkg::WB;
		end else begin
			sel = execPkg::REG;
		end
		return sel;
	endfunction

	always_comb begin
		forwardA = pickSource(ra1E, memStage.wa3, memStage.regWrite, wa3W, regWriteW);
		forwardB = pickSource(ra2E, memStage.wa3, memStage.regWrite, wa3W, regWriteW);
	end

	// --------------------
	// Checks
	// --------------------
	always_comb begin
		selectsValid: assert ((forwardA != 2'b11) && (forwardB != 2'b11))
		else $error("forwardUnit: unused select encoding");
	end

endmodule

`default_nettype wire

// File: design/exMemPipe.sv
`timescale 1ns/100ps
`default_nettype none

module exMemPipe (
	input  logic               Clk,
	input  logic               reset,
	input  execPkg::memStage_t stageIn,
	output execPkg::memStage_t stageOut
);

	logic        regWriteQ;
	logic        pcSrcQ;
	logic        memToRegQ;
	logic [31:0] aluResultQ;
	logic [31:0] writeDataQ;
	logic [3:0]  wa3Q;

	// --------------------
	// Control bits
	// --------------------
	always_ff @(posedge Clk) begin
		if (reset) begin
			regWriteQ <= 1'b0;
			pcSrcQ    <= 1'b0;
			memToRegQ <= 1'b0;
		end else begin
			regWriteQ <= stageIn.regWrite;
			pcSrcQ    <= stageIn.pcSrc;
			memToRegQ <= stageIn.memToReg;
		end
	end

	// Data path.
	always_ff @(posedge Clk) begin
		aluResultQ <= stageIn.aluResult;
		writeDataQ <= stageIn.writeData;
		wa3Q       <= stageIn.wa3;
	end

	assign stageOut = '{
		aluResult: aluResultQ,
		writeData: writeDataQ,
		wa3:       wa3Q,
		regWrite:  regWriteQ,
		pcSrc:     pcSrcQ,
		memToReg:  memToRegQ
	};

	noWriteAfterReset: assert property (
		@(posedge Clk) reset |=> !stageOut.regWrite
	) else $error("exMemPipe: regWrite set after reset");

endmodule

`default_nettype wire

// File: design/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute (
	input  logic               Clk,
	input  logic               reset,
	input  execPkg::exCtrl_t   exCtrl,
	input  logic        [31:0] dataRegA,
	input  logic        [31:0] dataRegB,
	input  logic        [31:0] dataRegC,
	input  logic        [31:0] extImm,
	input  logic        [31:0] resultW,
	input  execPkg::fwdSel_e   forwardA,
	input  execPkg::fwdSel_e   forwardB,
	input  execPkg::memStage_t memStage,    // Registered stage, fed back.
	output execPkg::memStage_t memStageOut,
	output logic               branchTaken,
	output execPkg::flags_t    flags
);

	logic [31:0]        srcA;
	logic [31:0]        srcBFwd;
	logic [31:0]        srcB;
	logic [31:0]        aluResult;
	execPkg::flags_t    aluFlags;
	logic               condEx;
	execPkg::memStage_t stageIn;

	function automatic logic [31:0] selectOperand(
		input execPkg::fwdSel_e sel,
		input logic [31:0]      regData,
		input logic [31:0]      wbData,
		input logic [31:0]      memData
	);
		logic [31:0] operand;
		case (sel)
			execPkg::WB:  operand = wbData;
			execPkg::MEM: operand = memData;
			default:      operand = regData;
		endcase
		return operand;
	endfunction

	// --------------------
	// Operand muxes
	// --------------------
	assign srcA    = selectOperand(forwardA, dataRegA, resultW, memStage.aluResult);
	assign srcBFwd = selectOperand(forwardB, dataRegB, resultW, memStage.aluResult);
	assign srcB    = exCtrl.aluSrc ? extImm : srcBFwd;

	alu u_alu (
		.inputA   (srcA),
		.inputB   (srcB),
		.inputC   (dataRegC),
		.aluOp    (exCtrl.aluOp),
		.result   (aluResult),
		.aluFlags (aluFlags)
	);

	condUnit u_condUnit (
		.Clk       (Clk),
		.reset     (reset),
		.aluFlags  (aluFlags),
		.cond      (exCtrl.cond),
		.flagWrite (exCtrl.flagWrite),
		.condEx    (condEx),
		.flags     (flags)
	);

	// --------------------
	// Condition gating
	// --------------------
	assign branchTaken = exCtrl.branch & condEx;

	assign stageIn = '{
		aluResult: aluResult,
		writeData: srcBFwd,                    // Store data skips the immediate mux.
		wa3:       exCtrl.wa3,
		regWrite:  exCtrl.regWrite & condEx,
		pcSrc:     exCtrl.pcSrc & condEx,
		memToReg:  exCtrl.memToReg
	};

	exMemPipe u_exMemPipe (
		.Clk      (Clk),
		.reset    (reset),
		.stageIn  (stageIn),
		.stageOut (memStageOut)
	);

endmodule

`default_nettype wire

// File: design/executeTop.sv
`timescale 1ns/100ps
`default_nettype none

module executeTop (
	input  logic               Clk,
	input  logic               reset,
	input  execPkg::exCtrl_t   exCtrl,
	input  logic        [3:0]  ra1E,
	input  logic        [3:0]  ra2E,
	input  logic        [31:0] dataRegA,
	input  logic        [31:0] dataRegB,
	input  logic        [31:0] dataRegC,
	input  logic        [31:0] extImm,
	input  logic        [31:0] resultW,
	input  logic        [3:0]  wa3W,
	input  logic               regWriteW,
	output execPkg::memStage_t memStage,
	output logic               branchTaken,
	output execPkg::flags_t    flags
);

	execPkg::fwdSel_e forwardA;
	execPkg::fwdSel_e forwardB;

	forwardUnit u_forwardUnit (
		.ra1E      (ra1E),
		.ra2E      (ra2E),
		.memStage  (memStage),
		.wa3W      (wa3W),
		.regWriteW (regWriteW),
		.forwardA  (forwardA),
		.forwardB  (forwardB)
	);

	execute u_execute (
		.Clk         (Clk),
		.reset       (reset),
		.exCtrl      (exCtrl),
		.dataRegA    (dataRegA),
		.dataRegB    (dataRegB),
		.dataRegC    (dataRegC),
		.extImm      (extImm),
		.resultW     (resultW),
		.forwardA    (forwardA),
		.forwardB    (forwardB),
		.memStage    (memStage),    // Loop back for MEM forwarding.
		.memStageOut (memStage),
		.branchTaken (branchTaken),
		.flags       (flags)
	);

endmodule

`default_nettype wire

// File: sim/execModel.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// --------------------
// Random source
// --------------------

// Sixteen-bit Fibonacci LFSR, taps 16, 14, 13 and 11.
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
	logic feedback;
	feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
	return {state[14:0], feedback};
endfunction

// --------------------
// Reference model
// --------------------

// Newest producer wins. MEM before WB before the register file.
function automatic logic [31:0] forwardedOperand(
	input logic [3:0]         src,
	input logic [31:0]        regData,
	input execPkg::memStage_t mem,
	input logic [3:0]         wbWa3,
	input logic               wbWrite,
	input logic [31:0]        wbData
);
	if (mem.regWrite && (mem.wa3 == src)) begin
		return mem.aluResult;
	end
	if (wbWrite && (wbWa3 == src)) begin
		return wbData;
	end
	return regData;
endfunction

function automatic logic [31:0] aluModel(
	input  execPkg::aluOp_e op,
	input  logic [31:0]     a,
	input  logic [31:0]     b,
	input  logic [31:0]     c,
	output execPkg::flags_t fl
);
	logic [32:0] wide;
	logic [63:0] prod;
	logic [31:0] r;
	logic        carry;
	logic        ovf;
	carry = 1'b0;
	ovf   = 1'b0;
	prod  = {32'd0, a} * {32'd0, b};
	case (op)
		execPkg::ADD: begin
			wide  = {1'b0, a} + {1'b0, b};
			r     = wide[31:0];
			carry = wide[32];
			ovf   = (a[31] == b[31]) && (r[31] != a[31]);
		end
		execPkg::SUB: begin
			r     = a - b;
			carry = (a >= b);                           // No borrow.
			ovf   = (a[31] != b[31]) && (r[31] != a[31]);
		end
		execPkg::RSB: begin
			r     = b - a;
			carry = (b >= a);
			ovf   = (a[31] != b[31]) && (r[31] != b[31]);
		end
		execPkg::AND: r = a & b;
		execPkg::ORR: r = a | b;
		execPkg::EOR: r = a ^ b;
		execPkg::BIC: r = a & ~b;
		execPkg::MOV: r = b;
		execPkg::MUL: r = prod[31:0];
		default:      r = prod[31:0] + c;               // MLA.
	endcase
	fl = '{n: r[31], z: (r == 32'd0), c: carry, v: ovf};
	return r;
endfunction

// Even codes test a base condition, odd codes its inverse.
function automatic logic condModel(input logic [3:0] cond, input execPkg::flags_t f);
	logic base;
	case (cond[3:1])
		3'd0:    base = f.z;
		3'd1:    base = f.c;
		3'd2:    base = f.n;
		3'd3:    base = f.v;
		3'd4:    base = f.c && !f.z;
		3'd5:    base = (f.n == f.v);
		3'd6:    base = !f.z && (f.n == f.v);
		default: base = 1'b1;
	endcase
	return (cond[3:1] == 3'd7) ? 1'b1 : (base ^ cond[0]);
endfunction

`endif

// File: sim/executeTb.sv
`timescale 1ns/100ps
`default_nettype none

module executeTb;

	localparam int instrCount    = 400;
	localparam int timeoutCycles = instrCount + 60;

	logic               Clk;
	logic               reset;
	execPkg::exCtrl_t   exCtrl;
	logic        [3:0]  ra1E;
	logic        [3:0]  ra2E;
	logic        [31:0] dataRegA;
	logic        [31:0] dataRegB;
	logic        [31:0] dataRegC;
	logic        [31:0] extImm;
	logic        [31:0] resultW;
	logic        [3:0]  wa3W;
	logic               regWriteW;
	execPkg::memStage_t memStage;
	logic               branchTaken;
	execPkg::flags_t    flags;

	logic        [15:0] lfsrState;
	execPkg::flags_t    modelFlags;
	execPkg::memStage_t expMem;       // Model copy of the pipeline register.
	int                 errorCount;
	int                 checkCount;

	`include "execModel.svh"

	executeTop u_executeTop (
		.Clk         (Clk),
		.reset       (reset),
		.exCtrl      (exCtrl),
		.ra1E        (ra1E),
		.ra2E        (ra2E),
		.dataRegA    (dataRegA),
		.dataRegB    (dataRegB),
		.dataRegC    (dataRegC),
		.extImm      (extImm),
		.resultW     (resultW),
		.wa3W        (wa3W),
		.regWriteW   (regWriteW),
		.memStage    (memStage),
		.branchTaken (branchTaken),
		.flags       (flags)
	);

	// --------------------
	// Helpers
	// --------------------
	function automatic logic takeBit();
		logic bitOut;
		bitOut    = lfsrState[15];
		lfsrState = lfsrNext(lfsrState);
		return bitOut;
	endfunction

	function automatic logic [31:0] takeBits(input int width);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[30:0], takeBit()};
		end
		return value;
	endfunction

	// Small values now and then, so zero results and equal operands show up.
	function automatic logic [31:0] randWord();
		logic [31:0] value;
		if (takeBit()) begin
			value = takeBits(3);
		end else begin
			value = takeBits(32);
		end
		return value;
	endfunction

	task automatic checkValue(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic compareStage(input string tag);
		checkValue({tag, " aluResult"}, expMem.aluResult, memStage.aluResult);
		checkValue({tag, " writeData"}, expMem.writeData, memStage.writeData);
		checkValue({tag, " wa3"}, 32'(expMem.wa3), 32'(memStage.wa3));
		checkValue({tag, " regWrite"}, 32'(expMem.regWrite), 32'(memStage.regWrite));
		checkValue({tag, " pcSrc"}, 32'(expMem.pcSrc), 32'(memStage.pcSrc));
		checkValue({tag, " memToReg"}, 32'(expMem.memToReg), 32'(memStage.memToReg));
		checkValue({tag, " flags"}, {28'd0, modelFlags}, {28'd0, flags});
	endtask

	// --------------------
	// Clock and watchdog
	// --------------------
	initial begin
		Clk = 1'b0;
		forever begin
			#5 Clk = ~Clk;
		end
	end

	initial begin
		repeat (timeoutCycles) #10;
		$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("=== FAIL ===");
		$finish;
	end

	// --------------------
	// Stimulus and checks
	// --------------------
	initial begin
		execPkg::exCtrl_t ctrl;
		execPkg::flags_t  aluFl;
		logic [31:0]      opA;
		logic [31:0]      opB;
		logic [31:0]      aluOut;
		logic             condPass;
		lfsrState  = 16'd48;
		errorCount = 0;
		checkCount = 0;
		reset      = 1'b1;
		exCtrl     = '0;
		exCtrl.regWrite  = 1'b1;          // Active controls while reset holds.
		exCtrl.pcSrc     = 1'b1;
		exCtrl.memToReg  = 1'b1;
		exCtrl.flagWrite = 1'b1;
		exCtrl.cond      = execPkg::AL;
		ra1E       = '0;
		ra2E       = '0;
		dataRegA   = '0;
		dataRegB   = '0;
		dataRegC   = '0;
		extImm     = '0;
		resultW    = '0;
		wa3W       = '0;
		regWriteW  = 1'b0;
		repeat (16) @(posedge Clk);
		@(negedge Clk);
		reset = 1'b0;

		checkValue("reset regWrite", 32'd0, 32'(memStage.regWrite));
		checkValue("reset pcSrc", 32'd0, 32'(memStage.pcSrc));
		checkValue("reset memToReg", 32'd0, 32'(memStage.memToReg));
		checkValue("reset flags", 32'd0, {28'd0, flags});
		modelFlags = '0;
		expMem     = '0;

		for (int i = 0; i < instrCount; i++) begin
			ctrl.regWrite  = takeBit();
			ctrl.pcSrc     = takeBit();
			ctrl.branch    = takeBit();
			ctrl.memToReg  = takeBit();
			ctrl.flagWrite = takeBit();
			ctrl.aluSrc    = takeBit();
			ctrl.aluOp     = execPkg::aluOp_e'(4'(takeBits(4) % 10));
			ctrl.cond      = execPkg::cond_e'(4'(takeBits(4)));  // Code 15 included.
			ctrl.wa3       = 4'(takeBits(2));                    // Narrow range.
			ra1E      = 4'(takeBits(2));
			ra2E      = 4'(takeBits(2));
			dataRegA  = randWord();
			dataRegB  = randWord();
			dataRegC  = randWord();
			extImm    = takeBits(8);
			resultW   = randWord();
			wa3W      = 4'(takeBits(2));
			regWriteW = takeBit();
			exCtrl    = ctrl;

			opA      = forwardedOperand(ra1E, dataRegA, expMem, wa3W, regWriteW, resultW);
			opB      = forwardedOperand(ra2E, dataRegB, expMem, wa3W, regWriteW, resultW);
			aluOut   = aluModel(ctrl.aluOp, opA, ctrl.aluSrc ? extImm : opB, dataRegC, aluFl);
			condPass = condModel(ctrl.cond, modelFlags);

			#2;
			checkValue($sformatf("instr %0d branchTaken", i), 32'(ctrl.branch & condPass),
				32'(branchTaken));

			expMem = '{
				aluResult: aluOut,
				writeData: opB,
				wa3:       ctrl.wa3,
				regWrite:  ctrl.regWrite & condPass,
				pcSrc:     ctrl.pcSrc & condPass,
				memToReg:  ctrl.memToReg
			};
			if (ctrl.flagWrite && condPass) begin
				modelFlags = aluFl;
			end

			@(negedge Clk);
			compareStage($sformatf("instr %0d", i));
		end

		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
design/execPkg.sv
design/alu.sv
design/condUnit.sv
design/forwardUnit.sv
design/exMemPipe.sv
design/execute.sv
design/executeTop.sv
sim/executeTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f tb.f --top-module executeTb -o executeTb &&
./obj_dir/executeTb | tee /dev/stderr | grep -qx "=== PASS ===" ||
{ echo "Simulation failed"; exit 1; }
echo "Simulation passed"
